// File: Bender.yml
package:
  name: vec_math

sources:
  - logic/vec_pkg.sv
  - logic/sync_fifo.sv
  - logic/vector_unit.sv
  - logic/dot_unit.sv
  - logic/result_merge.sv
  - logic/vec_math_top.sv
  - target: simulation
    files:
      - verif/vec_math_tb.sv

// File: build.f
logic/vec_pkg.sv
logic/sync_fifo.sv
logic/vector_unit.sv
logic/dot_unit.sv
logic/result_merge.sv
logic/vec_math_top.sv
verif/vec_math_tb.sv

// File: logic/dot_unit.sv
// Three-cycle dot product with a single shared multiplier
`timescale 1ns/10ps

module dot_unit
    import vec_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  vec_word_u x,
    input  vec_word_u y,
    input  logic      clear,
    output logic      done,
    output vec_word_u result
);

    logic                       busy;
    logic [1:0]                 lane;
    vec_word_u                  x_r;
    vec_word_u                  y_r;
    logic signed [D_BITS-1:0]   acc;
    logic signed [D_BITS-1:0]   mul_a;
    logic signed [D_BITS-1:0]   mul_b;
    logic signed [2*D_BITS-1:0] full_product;
    logic signed [D_BITS-1:0]   product;

    // Lane 0 straight from the inputs on start, later lanes from the captured words
    always_comb begin
        if (start) begin
            mul_a = x.vec[0];
            mul_b = y.vec[0];
        end else begin
            mul_a = x_r.vec[lane];
            mul_b = y_r.vec[lane];
        end
        full_product = mul_a * mul_b;
        product      = D_BITS'(full_product >>> Q_BITS);
    end

    always_ff @(posedge clock) begin
        if (start) begin
            x_r <= x;
            y_r <= y;
            acc <= product;
        end else if (busy) begin
            acc <= acc + product;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            lane <= 2'd0;
        end else if (start) begin
            busy <= 1'b1;
            lane <= 2'd1;
        end else if (busy) begin
            lane <= lane + 2'd1;
            if (lane == 2'd2) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (clear) begin
            done <= 1'b0;
        end
    end

    always_comb begin
        result           = '0;
        result.sc.scalar = acc;
    end

    assert property (@(posedge clock) disable iff (reset) start |-> !(busy || done))
        else $error("dot_unit: start while busy or done");

endmodule

// File: logic/result_merge.sv
// Command sequencer that starts both units and writes the matching result
`timescale 1ns/10ps

module result_merge
    import vec_pkg::*;
(
    input  logic               clock,
    input  logic               reset,

    // Command FIFO side
    input  logic               in_empty,
    output logic               in_rd_en,
    input  logic [OP_BITS-1:0] in_op,

    // Unit side
    output logic               start,
    input  logic               vec_done,
    input  vec_word_u          vec_result,
    input  logic               dot_done,
    input  vec_word_u          dot_result,
    output logic               unit_clear,

    // Result FIFO side
    input  logic               out_full,
    output logic               out_wr_en,
    output vec_word_u          out_result
);

    enum logic {st_idle, st_wait} state, next_state;
    logic [OP_BITS-1:0] op_r;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            op_r  <= OP_ADD;
        end else begin
            state <= next_state;
            if (start) begin
                op_r <= in_op;
            end
        end
    end

    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        start      = 1'b0;
        out_wr_en  = 1'b0;
        unit_clear = 1'b0;

        case (state)
            st_idle: begin
                // Pop the head and launch both units on it
                if (!in_empty) begin
                    in_rd_en   = 1'b1;
                    start      = 1'b1;
                    next_state = st_wait;
                end
            end
            st_wait: begin
                if (vec_done && dot_done && !out_full) begin
                    out_wr_en  = 1'b1;
                    unit_clear = 1'b1;
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    assign out_result = (op_r == OP_DOT) ? dot_result : vec_result;

    // Unit results only appear for a command in flight
    assert property (@(posedge clock) disable iff (reset)
                     (vec_done || dot_done) |-> state == st_wait)
        else $error("result_merge: unit done without a command in flight");

endmodule

// File: logic/sync_fifo.sv
// Single-clock first-word-fall-through FIFO with full and empty flags
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_wr;
    logic                       do_rd;

    assign full  = (count == DEPTH);
    assign empty = (count == 0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head is visible without a read
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) !(wr_en && full))
        else $error("sync_fifo: write while full");
    assert property (@(posedge clock) disable iff (reset) !(rd_en && empty))
        else $error("sync_fifo: read while empty");

endmodule

// File: logic/vec_math_top.sv
// Vector coprocessor top level with command and result queues
`timescale 1ns/10ps

module vec_math_top
    import vec_pkg::*;
(
    input  logic               clock,
    input  logic               reset,
    input  logic               in_wr_en,
    input  logic [OP_BITS-1:0] in_op,
    input  vec_word_u          in_x,
    input  vec_word_u          in_y,
    output logic               in_full,
    input  logic               out_rd_en,
    output vec_word_u          out_result,
    output logic               out_empty
);

    logic [CMD_BITS-1:0] cmd_dout;
    logic                cmd_empty;
    logic                cmd_rd_en;
    logic [OP_BITS-1:0]  head_op;
    vec_word_u           head_x;
    vec_word_u           head_y;
    logic                start;
    logic                unit_clear;
    logic                vec_done;
    vec_word_u           vec_result;
    logic                dot_done;
    vec_word_u           dot_result;
    logic                res_full;
    logic                res_wr_en;
    vec_word_u           res_din;

    assign {head_op, head_x, head_y} = cmd_dout;

    sync_fifo #(
        .WIDTH (CMD_BITS),
        .DEPTH (FIFO_DEPTH)
    ) cmd_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   ({in_op, in_x, in_y}),
        .full  (in_full),
        .rd_en (cmd_rd_en),
        .dout  (cmd_dout),
        .empty (cmd_empty)
    );

    vector_unit i_vector_unit (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .op     (head_op),
        .x      (head_x),
        .y      (head_y),
        .clear  (unit_clear),
        .done   (vec_done),
        .result (vec_result)
    );

    dot_unit i_dot_unit (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .x      (head_x),
        .y      (head_y),
        .clear  (unit_clear),
        .done   (dot_done),
        .result (dot_result)
    );

    result_merge i_result_merge (
        .clock      (clock),
        .reset      (reset),
        .in_empty   (cmd_empty),
        .in_rd_en   (cmd_rd_en),
        .in_op      (head_op),
        .start      (start),
        .vec_done   (vec_done),
        .vec_result (vec_result),
        .dot_done   (dot_done),
        .dot_result (dot_result),
        .unit_clear (unit_clear),
        .out_full   (res_full),
        .out_wr_en  (res_wr_en),
        .out_result (res_din)
    );

    sync_fifo #(
        .WIDTH ($bits(vec_word_u)),
        .DEPTH (FIFO_DEPTH)
    ) res_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (res_wr_en),
        .din   (res_din),
        .full  (res_full),
        .rd_en (out_rd_en),
        .dout  (out_result),
        .empty (out_empty)
    );

endmodule

// File: logic/vec_pkg.sv
// Shared widths, operation codes and the vector/scalar word union
package vec_pkg;

    // One Q16.16 component
    localparam int D_BITS = 32;
    localparam int Q_BITS = 16;

    // Operation codes
    localparam int OP_BITS = 2;
    localparam logic [OP_BITS-1:0] OP_ADD   = 2'd0;
    localparam logic [OP_BITS-1:0] OP_CROSS = 2'd1;
    localparam logic [OP_BITS-1:0] OP_SCALE = 2'd2;
    localparam logic [OP_BITS-1:0] OP_DOT   = 2'd3;

    // Command entry is op followed by two operand words
    localparam int CMD_BITS = OP_BITS + 2 * 3 * D_BITS;

    // Entry count of command and result queues
    localparam int FIFO_DEPTH = 4;

    // 96-bit operand or result word
    // vec: three lanes, lane 0 in the low bits
    // sc:  scalar in the low lane, upper 64 bits unused
    typedef union packed {
        logic [2:0][D_BITS-1:0] vec;
        struct packed {
            logic [2*D_BITS-1:0]      pad;
            logic signed [D_BITS-1:0] scalar;
        } sc;
    } vec_word_u;

endpackage

// File: logic/vector_unit.sv
// One-cycle registered add, cross and scale of two operand words
`timescale 1ns/10ps

module vector_unit
    import vec_pkg::*;
(
    input  logic               clock,
    input  logic               reset,
    input  logic               start,
    input  logic [OP_BITS-1:0] op,
    input  vec_word_u          x,
    input  vec_word_u          y,
    input  logic               clear,
    output logic               done,
    output vec_word_u          result
);

    vec_word_u next_result;

    // Fixed-point product, shifted back to Q16.16 and truncated
    function automatic logic signed [D_BITS-1:0] q_mul(
        input logic signed [D_BITS-1:0] a,
        input logic signed [D_BITS-1:0] b
    );
        logic signed [2*D_BITS-1:0] p;
        p = a * b;
        return D_BITS'(p >>> Q_BITS);
    endfunction

    // a*b - c*d kept at full width before the shift
    function automatic logic signed [D_BITS-1:0] q_cross(
        input logic signed [D_BITS-1:0] a,
        input logic signed [D_BITS-1:0] b,
        input logic signed [D_BITS-1:0] c,
        input logic signed [D_BITS-1:0] d
    );
        logic signed [2*D_BITS:0] diff;
        diff = a * b - c * d;
        return D_BITS'(diff >>> Q_BITS);
    endfunction

    always_comb begin
        next_result = result;
        case (op)
            OP_ADD: begin
                for (int i = 0; i < 3; i++) begin
                    next_result.vec[i] = x.vec[i] + y.vec[i];
                end
            end
            OP_CROSS: begin
                next_result.vec[0] = q_cross(x.vec[1], y.vec[2], x.vec[2], y.vec[1]);
                next_result.vec[1] = q_cross(x.vec[2], y.vec[0], x.vec[0], y.vec[2]);
                next_result.vec[2] = q_cross(x.vec[0], y.vec[1], x.vec[1], y.vec[0]);
            end
            OP_SCALE: begin
                for (int i = 0; i < 3; i++) begin
                    next_result.vec[i] = q_mul(x.vec[i], y.sc.scalar);
                end
            end
            // Dot is handled by the dot unit
            default: next_result = result;
        endcase
    end

    always_ff @(posedge clock) begin
        if (start) begin
            result <= next_result;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b1;
        end else if (clear) begin
            done <= 1'b0;
        end
    end

    assert property (@(posedge clock) disable iff (reset) start |-> !done)
        else $error("vector_unit: start while previous result not cleared");

endmodule

// File: verif/vec_math_tb.sv
// Testbench for the vector coprocessor with reference model, LCG, checks and directed tests
`timescale 1ns/10ps

module vec_math_tb
    import vec_pkg::*;
;

    localparam int CLK_PERIOD = 100;
    localparam int WAIT_BOUND = 100;
    localparam int FLAG_FULL  = 0;
    localparam int FLAG_EMPTY = 1;
    localparam logic [D_BITS-1:0] ONE = 32'h0001_0000;

    // Commands per test
    localparam int ADD_CMDS   = 4;
    localparam int CROSS_CMDS = 7;
    localparam int SCALE_CMDS = 5;
    localparam int DOT_CMDS   = 5;
    localparam int BP_CMDS    = 12;
    localparam int TOTAL_CMDS = ADD_CMDS + CROSS_CMDS + SCALE_CMDS + DOT_CMDS + BP_CMDS;
    localparam int WATCHDOG_CYCLES = TOTAL_CMDS * 200 + 100;

    // Commands held once both queues and the units are full
    localparam int STALL_CMDS = 2 * FIFO_DEPTH + 1;

    logic               clock;
    logic               reset;
    logic               in_wr_en;
    logic [OP_BITS-1:0] in_op;
    vec_word_u          in_x;
    vec_word_u          in_y;
    logic               in_full;
    logic               out_rd_en;
    vec_word_u          out_result;
    logic               out_empty;

    logic [31:0]        lcg_state = 32'h8271;
    vec_word_u          exp_q[$];
    logic [OP_BITS-1:0] op_q[$];

    vec_math_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .in_wr_en   (in_wr_en),
        .in_op      (in_op),
        .in_x       (in_x),
        .in_y       (in_y),
        .in_full    (in_full),
        .out_rd_en  (out_rd_en),
        .out_result (out_result),
        .out_empty  (out_empty)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random lane within +-16.0
    function automatic logic [D_BITS-1:0] rand_lane();
        logic [31:0] r;
        r = lcg_next();
        return {{11{r[30]}}, r[30:10]};
    endfunction

    function automatic vec_word_u make_word(input logic [D_BITS-1:0] l0,
                                            input logic [D_BITS-1:0] l1,
                                            input logic [D_BITS-1:0] l2);
        vec_word_u w;
        w.vec[0] = l0;
        w.vec[1] = l1;
        w.vec[2] = l2;
        return w;
    endfunction

    function automatic vec_word_u rand_word();
        return make_word(rand_lane(), rand_lane(), rand_lane());
    endfunction

    // (a*b - c*d) in 64 bits, then >>> 16 and keep the low 32 bits
    function automatic logic [D_BITS-1:0] fx_diff(input logic signed [D_BITS-1:0] a,
                                                  input logic signed [D_BITS-1:0] b,
                                                  input logic signed [D_BITS-1:0] c,
                                                  input logic signed [D_BITS-1:0] d);
        longint la;
        longint lb;
        longint lc;
        longint ld;
        longint p;
        la = a;
        lb = b;
        lc = c;
        ld = d;
        p = la * lb - lc * ld;
        return D_BITS'(p >>> Q_BITS);
    endfunction

    function automatic vec_word_u model(input logic [OP_BITS-1:0] op,
                                        input vec_word_u x,
                                        input vec_word_u y);
        vec_word_u r;
        logic [D_BITS-1:0] acc;
        r = '0;
        acc = '0;
        case (op)
            OP_ADD: begin
                for (int i = 0; i < 3; i++) begin
                    r.vec[i] = x.vec[i] + y.vec[i];
                end
            end
            OP_CROSS: begin
                r.vec[0] = fx_diff(x.vec[1], y.vec[2], x.vec[2], y.vec[1]);
                r.vec[1] = fx_diff(x.vec[2], y.vec[0], x.vec[0], y.vec[2]);
                r.vec[2] = fx_diff(x.vec[0], y.vec[1], x.vec[1], y.vec[0]);
            end
            OP_SCALE: begin
                for (int i = 0; i < 3; i++) begin
                    r.vec[i] = fx_diff(x.vec[i], y.sc.scalar, 0, 0);
                end
            end
            default: begin
                for (int i = 0; i < 3; i++) begin
                    acc = acc + fx_diff(x.vec[i], y.vec[i], 0, 0);
                end
                r.sc.scalar = acc;
            end
        endcase
        return r;
    endfunction

    task automatic check_vec(input string name, input vec_word_u exp, input vec_word_u act);
        for (int i = 0; i < 3; i++) begin
            if (act.vec[i] !== exp.vec[i]) begin
                $display("[ERROR] %s[%0d] expected %h actual %h",
                         name, i, exp.vec[i], act.vec[i]);
                fail_run("Vector result does not match");
            end
        end
    endtask

    task automatic check_scalar(input string name, input vec_word_u exp, input vec_word_u act);
        if (act.sc.scalar !== exp.sc.scalar) begin
            $display("[ERROR] %s expected %h actual %h", name, exp.sc.scalar, act.sc.scalar);
            fail_run("Scalar result does not match");
        end
    endtask

    // Sampled on the falling edge, away from the driving edge
    task automatic wait_flag(input int which, input logic level, input string what);
        int n;
        n = 0;
        @(negedge clock);
        while (((which == FLAG_FULL) ? in_full : out_empty) !== level) begin
            if (n == WAIT_BOUND) begin
                fail_run($sformatf("Gave up waiting for %s", what));
            end else begin
                n++;
                @(negedge clock);
            end
        end
    endtask

    task automatic send_cmd_exp(input logic [OP_BITS-1:0] op, input vec_word_u x,
                                input vec_word_u y, input vec_word_u exp);
        wait_flag(FLAG_FULL, 1'b0, "room in the command FIFO");
        @(posedge clock);
        in_wr_en <= 1'b1;
        in_op    <= op;
        in_x     <= x;
        in_y     <= y;
        @(posedge clock);
        in_wr_en <= 1'b0;
        op_q.push_back(op);
        exp_q.push_back(exp);
    endtask

    task automatic send_cmd(input logic [OP_BITS-1:0] op, input vec_word_u x,
                            input vec_word_u y);
        send_cmd_exp(op, x, y, model(op, x, y));
    endtask

    task automatic read_result();
        vec_word_u          act;
        vec_word_u          exp;
        logic [OP_BITS-1:0] op;
        wait_flag(FLAG_EMPTY, 1'b0, "a result in the output FIFO");
        act = out_result;
        @(posedge clock);
        out_rd_en <= 1'b1;
        @(posedge clock);
        out_rd_en <= 1'b0;
        exp = exp_q.pop_front();
        op  = op_q.pop_front();
        if (op == OP_DOT) begin
            check_scalar("out_result.sc.scalar", exp, act);
        end else begin
            check_vec("out_result.vec", exp, act);
        end
    endtask

    task automatic drain(input int n);
        for (int i = 0; i < n; i++) begin
            read_result();
        end
    endtask

    task automatic test_add();
        send_cmd_exp(OP_ADD, make_word(ONE, 32'h0002_0000, 32'hFFFF_0000),
                     make_word(ONE, ONE, ONE), make_word(32'h0002_0000, 32'h0003_0000, 0));
        // Lane 0 wraps past the largest positive value
        send_cmd_exp(OP_ADD, make_word(32'h7FFF_0000, 5, 32'h8000_0000),
                     make_word(32'h0002_0000, 0, 32'hFFFF_0000),
                     make_word(32'h8001_0000, 5, 32'h7FFF_0000));
        for (int i = 0; i < ADD_CMDS - 2; i++) begin
            send_cmd(OP_ADD, rand_word(), rand_word());
        end
        drain(ADD_CMDS);
    endtask

    task automatic test_cross();
        vec_word_u ex;
        vec_word_u ey;
        vec_word_u ez;
        ex = make_word(ONE, 0, 0);
        ey = make_word(0, ONE, 0);
        ez = make_word(0, 0, ONE);
        send_cmd_exp(OP_CROSS, ex, ey, ez);
        send_cmd_exp(OP_CROSS, ey, ez, ex);
        send_cmd_exp(OP_CROSS, ez, ex, ey);
        for (int i = 0; i < CROSS_CMDS - 3; i++) begin
            send_cmd(OP_CROSS, rand_word(), rand_word());
        end
        drain(CROSS_CMDS);
    endtask

    task automatic test_scale();
        vec_word_u y;
        // Scalar -0.5 with random padding; 2^-16 * -0.5 rounds down to -2^-16
        y = rand_word();
        y.sc.scalar = 32'hFFFF_8000;
        send_cmd_exp(OP_SCALE, make_word(ONE, 32'h0003_0000, 1), y,
                     make_word(32'hFFFF_8000, 32'hFFFE_8000, 32'hFFFF_FFFF));
        for (int i = 0; i < SCALE_CMDS - 1; i++) begin
            send_cmd(OP_SCALE, rand_word(), rand_word());
        end
        drain(SCALE_CMDS);
    endtask

    task automatic test_dot();
        vec_word_u exp;
        exp = '0;
        exp.sc.scalar = 32'h000C_0000;
        send_cmd_exp(OP_DOT, make_word(ONE, 32'h0002_0000, 32'h0003_0000),
                     make_word(32'h0004_0000, 32'hFFFB_0000, 32'h0006_0000), exp);
        for (int i = 0; i < DOT_CMDS - 1; i++) begin
            send_cmd(OP_DOT, rand_word(), rand_word());
        end
        drain(DOT_CMDS);
    endtask

    task automatic test_backpressure();
        fork
            begin
                for (int i = 0; i < BP_CMDS; i++) begin
                    send_cmd(OP_BITS'(i % 4), rand_word(), rand_word());
                end
            end
            begin
                // Full with every slot taken means the merger holds on a full result FIFO
                wait_flag(FLAG_FULL, 1'b1, "in_full to rise while results are held");
                while (op_q.size() < STALL_CMDS) begin
                    wait_flag(FLAG_FULL, 1'b1, "in_full to rise while results are held");
                end
                read_result();
                wait_flag(FLAG_FULL, 1'b0, "in_full to fall after reading resumed");
                drain(BP_CMDS - 1);
            end
        join
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Timeout: the tests did not finish in the expected time");
    end

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        in_op     = OP_ADD;
        in_x      = '0;
        in_y      = '0;
        out_rd_en = 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        test_add();
        test_cross();
        test_scale();
        test_dot();
        test_backpressure();

        @(negedge clock);
        if (out_empty !== 1'b1) begin
            fail_run("The result FIFO holds a result that no command asked for");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
